// ==== list.f ====
hw/video_pkg.sv
hw/overlay_pkg.sv
hw/fg_request_gen.sv
hw/fg_clip.sv
hw/bg_delay_line.sv
hw/pixel_blend.sv
hw/overlay_pipeline.sv
sim/fg_memory_model.sv
sim/overlay_pipeline_tb.sv

// ==== sim/overlay_pipeline_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module overlay_pipeline_tb;

    import video_pkg::*;
    import overlay_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    localparam int REQ_LATENCY  = 1;
    localparam int OUT_LATENCY  = 7;
    localparam int DRAIN_LIMIT  = 20;
    localparam int OFF_PIXELS   = 48;
    localparam int SCALE_PIXELS = 24;
    localparam int CLIP_PIXELS  = 40;
    localparam int KEY_PIXELS   = 32;
    localparam int ALPHA_PIXELS = 8;
    localparam int TOTAL_PIXELS = OFF_PIXELS + 4 * SCALE_PIXELS + 2 * CLIP_PIXELS +
                                  KEY_PIXELS + 8 * ALPHA_PIXELS;
    localparam int WATCHDOG_NS  = (TOTAL_PIXELS + 50) * CLK_PERIOD * 2;

    typedef struct packed {
        int          cycle;
        fg_request_t req;
        logic        active;
    } request_item_t;

    typedef struct packed {
        int            cycle;
        screen_pixel_t pix;
    } output_item_t;

    logic          clk = 1'b0;
    logic          rst_n;
    screen_pixel_t bg;
    logic          bg_valid;
    overlay_ctrl_t ctrl;
    fg_request_t   fg_request;
    logic          fg_request_active;
    pixel_t        fg_pixel;
    logic          fg_valid;
    screen_pixel_t pix_out;
    logic          pix_out_valid;

    request_item_t req_q[$];
    output_item_t  out_q[$];
    int            cycle_count = 0;
    logic          checking = 1'b0;
    int            error_count = 0;
    int            errors_at_start;
    int            tests_passed = 0;
    int            tests_failed = 0;
    int            out_run = 0;
    int            max_out_run;
    int            seed_value;
    string         current_test;

    overlay_pipeline dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .bg                (bg),
        .bg_valid          (bg_valid),
        .ctrl              (ctrl),
        .fg_request        (fg_request),
        .fg_request_active (fg_request_active),
        .fg_pixel          (fg_pixel),
        .fg_valid          (fg_valid),
        .pix_out           (pix_out),
        .pix_out_valid     (pix_out_valid)
    );

    fg_memory_model u_memory (
        .clk            (clk),
        .rst_n          (rst_n),
        .request        (fg_request),
        .request_active (fg_request_active),
        .pixel          (fg_pixel),
        .pixel_valid    (fg_valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk)
        cycle_count <= cycle_count + 1;

    // --------------------
    // Compare tasks
    // --------------------

    task automatic check_pixel(input pixel_t actual, input pixel_t expected, input string what);
        if (actual !== expected)
        begin
            error_count++;
            $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_coord(input coord_t actual, input coord_t expected, input string what);
        if (actual !== expected)
        begin
            error_count++;
            $display("[ERROR] %0d ns: %s is %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic check_request(input fg_request_t actual, input fg_request_t expected,
                                 input string what);
        if (actual !== expected)
        begin
            error_count++;
            $display("[ERROR] %0d ns: %s is (%0d, %0d), expected (%0d, %0d)", $time, what,
                     actual.x, actual.y, expected.x, expected.y);
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected)
        begin
            error_count++;
            $display("[ERROR] %0d ns: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    // --------------------
    // Reference model
    // --------------------

    // Arithmetic shift of a signed int rounds toward minus infinity
    function automatic int model_coord(input int pos, input int offset, input int shift);
        return (pos - offset) >>> shift;
    endfunction

    function automatic logic model_active(input int fx, input int fy);
        logic in_image;
        logic in_window;
        in_image  = fx >= 0 && fx < FG_WIDTH && fy >= 0 && fy < FG_HEIGHT;
        in_window = fx >= int'(ctrl.clip_left) && fx <= int'(ctrl.clip_right) &&
                    fy >= int'(ctrl.clip_top) && fy <= int'(ctrl.clip_bottom);
        return in_image && in_window;
    endfunction

    // Same image the memory model holds
    function automatic pixel_t model_fg_pixel(input int fx, input int fy);
        int sum;
        sum = fx + fy;
        return {fx[4:0], fy[5:0], sum[4:0]};
    endfunction

    function automatic pixel_t weighted_mix(input pixel_t fg, input pixel_t bg_pix,
                                            input alpha_t t);
        int wt;
        int r;
        int g;
        int b;
        wt = int'(t);
        r  = (int'(fg[15:11]) * (8 - wt) + int'(bg_pix[15:11]) * wt) / 8;
        g  = (int'(fg[10:5]) * (8 - wt) + int'(bg_pix[10:5]) * wt) / 8;
        b  = (int'(fg[4:0]) * (8 - wt) + int'(bg_pix[4:0]) * wt) / 8;
        return {r[4:0], g[5:0], b[4:0]};
    endfunction

    function automatic screen_pixel_t expected_result(input screen_pixel_t in_pix);
        int            fx;
        int            fy;
        pixel_t        fg;
        logic          show_fg;
        screen_pixel_t res;
        fx      = model_coord(int'(in_pix.x), ctrl.offset_x, int'(ctrl.scale));
        fy      = model_coord(int'(in_pix.y), ctrl.offset_y, int'(ctrl.scale));
        fg      = model_fg_pixel(fx, fy);
        show_fg = model_active(fx, fy) && (ctrl.mode == MODE_OVERLAY ||
                  (ctrl.mode == MODE_CHROMA_KEY && fg != ctrl.key_color));
        res     = in_pix;
        if (show_fg)
            res.pixel = weighted_mix(fg, in_pix.pixel, ctrl.transparency);
        return res;
    endfunction

    // --------------------
    // Monitor
    // --------------------

    // Registered outputs are sampled on the falling edge
    always @(negedge clk)
    begin : monitor
        request_item_t ri;
        output_item_t  oi;
        if (checking)
        begin
            if (req_q.size() > 0 && req_q[0].cycle == cycle_count)
            begin
                ri = req_q.pop_front();
                check_flag(fg_request_active, ri.active, "fg_request_active");
                check_request(fg_request, ri.req, "fg_request");
            end
            else if (fg_request_active !== 1'b0)
            begin
                error_count++;
                $display("At %0d ns fg_request_active is high without a strobe before it", $time);
            end
            while (out_q.size() > 0 && out_q[0].cycle < cycle_count)
            begin
                oi = out_q.pop_front();
                error_count++;
                $display("At %0d ns the result for pixel (%0d, %0d) never arrived",
                         $time, oi.pix.x, oi.pix.y);
            end
            if (pix_out_valid === 1'b1)
            begin
                if (out_q.size() > 0 && out_q[0].cycle == cycle_count)
                begin
                    oi = out_q.pop_front();
                    check_coord(pix_out.x, oi.pix.x, "pix_out.x");
                    check_coord(pix_out.y, oi.pix.y, "pix_out.y");
                    check_pixel(pix_out.pixel, oi.pix.pixel, "pix_out.pixel");
                    // Back-to-back results on time mean their strobes overlapped
                    out_run++;
                    if (out_run > max_out_run)
                        max_out_run = out_run;
                end
                else
                begin
                    out_run = 0;
                    error_count++;
                    $display("At %0d ns pix_out_valid is high but no result is due", $time);
                end
            end
            else
                out_run = 0;
        end
    end

    // --------------------
    // Stimulus helpers
    // --------------------

    function automatic coord_t random_coord(input int lo, input int hi);
        return coord_t'($urandom_range(hi, lo));
    endfunction

    // Fully open clip window with no offset and no scaling
    function automatic overlay_ctrl_t open_ctrl(input overlay_mode_e mode);
        overlay_ctrl_t c;
        c             = '0;
        c.mode        = mode;
        c.clip_right  = coord_t'(2047);
        c.clip_bottom = coord_t'(2047);
        return c;
    endfunction

    task automatic send_pixel(input coord_t x, input coord_t y, input pixel_t p);
        screen_pixel_t sp;
        request_item_t ri;
        output_item_t  oi;
        int            fx;
        int            fy;
        @(negedge clk);
        sp.pixel  = p;
        sp.x      = x;
        sp.y      = y;
        bg        = sp;
        bg_valid  = 1'b1;
        fx        = model_coord(int'(x), ctrl.offset_x, int'(ctrl.scale));
        fy        = model_coord(int'(y), ctrl.offset_y, int'(ctrl.scale));
        ri.cycle  = cycle_count + REQ_LATENCY;
        ri.req.x  = fg_coord_t'(fx);
        ri.req.y  = fg_coord_t'(fy);
        ri.active = model_active(fx, fy);
        req_q.push_back(ri);
        oi.cycle  = cycle_count + OUT_LATENCY;
        oi.pix    = expected_result(sp);
        out_q.push_back(oi);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(negedge clk);
            bg_valid = 1'b0;
        end
    endtask

    task automatic wait_drain();
        int guard;
        idle_cycles(1);
        guard = 0;
        while ((out_q.size() > 0 || req_q.size() > 0) && guard < DRAIN_LIMIT)
        begin
            @(negedge clk);
            guard++;
        end
        if (out_q.size() > 0)
        begin
            error_count++;
            $display("Pipeline did not drain, %0d results still outstanding", out_q.size());
            out_q.delete();
        end
    endtask

    task automatic start_test(input string name);
        current_test    = name;
        errors_at_start = error_count;
    endtask

    task automatic finish_test();
        if (error_count == errors_at_start)
        begin
            tests_passed++;
            $display("%-20s passed", current_test);
        end
        else
        begin
            tests_failed++;
            $display("%-20s failed, %0d errors", current_test, error_count - errors_at_start);
        end
    endtask

    // --------------------
    // Directed tests
    // --------------------

    task automatic test_reset();
        start_test("reset");
        repeat (RESET_CYCLES)
        begin
            @(negedge clk);
            check_flag(pix_out_valid, 1'b0, "pix_out_valid in reset");
            check_flag(fg_request_active, 1'b0, "fg_request_active in reset");
        end
        rst_n = 1'b1;
        repeat (10)
        begin
            @(negedge clk);
            check_flag(pix_out_valid, 1'b0, "pix_out_valid after reset");
            check_flag(fg_request_active, 1'b0, "fg_request_active after reset");
        end
        finish_test();
    endtask

    task automatic test_off_mode();
        int sent;
        int burst;
        start_test("off mode latency");
        ctrl        = open_ctrl(MODE_OFF);
        max_out_run = 0;
        sent        = 0;
        while (sent < OFF_PIXELS)
        begin
            burst = $urandom_range(8, 1);
            for (int i = 0; i < burst && sent < OFF_PIXELS; i++)
            begin
                send_pixel(random_coord(0, RES_X - 1), random_coord(0, RES_Y - 1),
                           pixel_t'($urandom));
                sent++;
            end
            idle_cycles($urandom_range(3, 1));
        end
        wait_drain();
        if (max_out_run < 2)
        begin
            error_count++;
            $display("Off mode never returned results on consecutive cycles");
        end
        finish_test();
    endtask

    task automatic test_scale_offset();
        start_test("scale and offset");
        for (int s = 0; s < 4; s++)
        begin
            ctrl          = open_ctrl(MODE_OVERLAY);
            ctrl.scale    = fg_scale_t'(s);
            ctrl.offset_x = fg_coord_t'(-40);
            ctrl.offset_y = fg_coord_t'(30);
            // Top row maps to a negative foreground row
            send_pixel(coord_t'(0), coord_t'(0), pixel_t'($urandom));
            for (int i = 1; i < SCALE_PIXELS; i++)
                send_pixel(random_coord(0, RES_X - 1), random_coord(0, RES_Y - 1),
                           pixel_t'($urandom));
            wait_drain();
        end
        finish_test();
    endtask

    task automatic test_clip();
        start_test("clip window");
        ctrl             = open_ctrl(MODE_OVERLAY);
        ctrl.scale       = fg_scale_t'(1);
        ctrl.clip_left   = coord_t'(32);
        ctrl.clip_right  = coord_t'(95);
        ctrl.clip_top    = coord_t'(20);
        ctrl.clip_bottom = coord_t'(60);
        for (int i = 0; i < CLIP_PIXELS; i++)
            send_pixel(random_coord(0, 300), random_coord(0, 200), pixel_t'($urandom));
        wait_drain();
        // Inverted window blocks everything
        ctrl.clip_left  = coord_t'(100);
        ctrl.clip_right = coord_t'(50);
        ctrl.clip_top   = coord_t'(10);
        ctrl.clip_bottom = coord_t'(150);
        for (int i = 0; i < CLIP_PIXELS; i++)
            send_pixel(random_coord(0, 300), random_coord(0, 200), pixel_t'($urandom));
        wait_drain();
        finish_test();
    endtask

    task automatic test_chroma_key();
        start_test("chroma key");
        ctrl           = open_ctrl(MODE_CHROMA_KEY);
        ctrl.key_color = model_fg_pixel(10, 20);
        for (int i = 0; i < KEY_PIXELS; i++)
        begin
            // Every fourth pixel hits a position holding the key colour
            if (i % 4 == 0)
                send_pixel(coord_t'(10 + 32 * $urandom_range(7, 0)),
                           coord_t'(20 + 64 * $urandom_range(2, 0)), pixel_t'($urandom));
            else
                send_pixel(random_coord(0, FG_WIDTH - 1), random_coord(0, FG_HEIGHT - 1),
                           pixel_t'($urandom));
        end
        wait_drain();
        finish_test();
    endtask

    task automatic test_transparency();
        start_test("transparency");
        for (int t = 0; t < 8; t++)
        begin
            ctrl              = open_ctrl(MODE_OVERLAY);
            ctrl.transparency = alpha_t'(t);
            for (int i = 0; i < ALPHA_PIXELS; i++)
                send_pixel(random_coord(0, FG_WIDTH - 1), random_coord(0, FG_HEIGHT - 1),
                           pixel_t'($urandom));
            wait_drain();
        end
        finish_test();
    endtask

    // --------------------
    // Main sequence
    // --------------------

    initial
    begin
        seed_value = $urandom(32'h6623);
        rst_n      = 1'b0;
        bg         = '0;
        bg_valid   = 1'b0;
        ctrl       = open_ctrl(MODE_OFF);
        test_reset();
        checking = 1'b1;
        test_off_mode();
        test_scale_offset();
        test_clip();
        test_chroma_key();
        test_transparency();
        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (error_count == 0 && tests_failed == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/fg_memory_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module fg_memory_model (
    input  logic                     clk,
    input  logic                     rst_n,
    input  overlay_pkg::fg_request_t request,
    input  logic                     request_active,
    output video_pkg::pixel_t        pixel,
    output logic                     pixel_valid
);

    import video_pkg::*;
    import overlay_pkg::*;

    // The request shows up one cycle after its strobe, the rest of the fetch delay is spent here
    localparam int LATENCY = FG_FETCH_DELAY - 1;

    pixel_t             stage_pixel [LATENCY];
    logic [LATENCY-1:0] stage_valid = '0;

    // Image content derived from the address
    function automatic pixel_t stored_pixel(input fg_request_t req);
        logic [FG_COORD_WIDTH-1:0] sum;
        sum = req.x + req.y;
        return {req.x[R_WIDTH-1:0], req.y[G_WIDTH-1:0], sum[B_WIDTH-1:0]};
    endfunction

    always @(posedge clk)
    begin
        if (!rst_n)
            stage_valid <= '0;
        else
            stage_valid <= {stage_valid[LATENCY-2:0], request_active};
    end

    always @(posedge clk)
    begin
        stage_pixel[0] <= stored_pixel(request);
        for (int i = 1; i < LATENCY; i++)
            stage_pixel[i] <= stage_pixel[i-1];
    end

    assign pixel       = stage_pixel[LATENCY-1];
    assign pixel_valid = stage_valid[LATENCY-1];

endmodule

`default_nettype wire

// ==== hw/overlay_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module overlay_pipeline (
    input  logic                       clk,
    input  logic                       rst_n,

    // Background stream
    input  overlay_pkg::screen_pixel_t bg,
    input  logic                       bg_valid,

    // Static controls, changed only while idle
    input  overlay_pkg::overlay_ctrl_t ctrl,

    // Foreground memory port
    output overlay_pkg::fg_request_t   fg_request,
    output logic                       fg_request_active,
    input  video_pkg::pixel_t          fg_pixel,
    input  logic                       fg_valid,

    // Composited result
    output overlay_pkg::screen_pixel_t pix_out,
    output logic                       pix_out_valid
);

    import overlay_pkg::*;

    logic          raw_active;
    screen_pixel_t held;
    logic          held_valid;

    // --------------------
    // Foreground request
    // --------------------

    fg_request_gen u_request_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .x          (bg.x),
        .y          (bg.y),
        .bg_valid   (bg_valid),
        .scale      (ctrl.scale),
        .offset_x   (ctrl.offset_x),
        .offset_y   (ctrl.offset_y),
        .request    (fg_request),
        .raw_active (raw_active)
    );

    fg_clip u_clip (
        .request     (fg_request),
        .raw_active  (raw_active),
        .clip_left   (ctrl.clip_left),
        .clip_right  (ctrl.clip_right),
        .clip_top    (ctrl.clip_top),
        .clip_bottom (ctrl.clip_bottom),
        .active      (fg_request_active)
    );

    // --------------------
    // Background hold and merge
    // --------------------

    // Background waits here while the memory fetches
    bg_delay_line u_delay_line (
        .clk        (clk),
        .rst_n      (rst_n),
        .bg         (bg),
        .bg_valid   (bg_valid),
        .held       (held),
        .held_valid (held_valid)
    );

    pixel_blend u_blend (
        .clk           (clk),
        .rst_n         (rst_n),
        .held          (held),
        .held_valid    (held_valid),
        .fg_pixel      (fg_pixel),
        .fg_valid      (fg_valid),
        .ctrl          (ctrl),
        .pix_out       (pix_out),
        .pix_out_valid (pix_out_valid)
    );

endmodule

`default_nettype wire

// ==== hw/pixel_blend.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_blend (
    input  logic                       clk,
    input  logic                       rst_n,
    input  overlay_pkg::screen_pixel_t held,
    input  logic                       held_valid,
    input  video_pkg::pixel_t          fg_pixel,
    input  logic                       fg_valid,
    input  overlay_pkg::overlay_ctrl_t ctrl,
    output overlay_pkg::screen_pixel_t pix_out,
    output logic                       pix_out_valid
);

    import video_pkg::*;
    import overlay_pkg::*;

    red_t   fg_r;
    green_t fg_g;
    blue_t  fg_b;
    red_t   bg_r;
    green_t bg_g;
    blue_t  bg_b;
    red_t   mix_r;
    green_t mix_g;
    blue_t  mix_b;
    logic   mode_fg;
    logic   use_fg;
    pixel_t result;

    // Weighted average over eighths, sized for the widest channel
    function automatic green_t blend_channel(
        input green_t fg,
        input green_t bg,
        input alpha_t t
    );
        logic [3:0] w_fg;
        logic [9:0] sum;
        w_fg = 4'd8 - {1'b0, t};
        sum  = fg * w_fg + bg * t;
        return sum[8:3];
    endfunction

    // --------------------
    // Channel split
    // --------------------

    assign fg_r = fg_pixel[PIXEL_WIDTH-1 -: R_WIDTH];
    assign fg_g = fg_pixel[B_WIDTH +: G_WIDTH];
    assign fg_b = fg_pixel[0 +: B_WIDTH];

    assign bg_r = held.pixel[PIXEL_WIDTH-1 -: R_WIDTH];
    assign bg_g = held.pixel[B_WIDTH +: G_WIDTH];
    assign bg_b = held.pixel[0 +: B_WIDTH];

    // --------------------
    // Mode and blend
    // --------------------

    always_comb
    begin
        case (ctrl.mode)
            MODE_OVERLAY:    mode_fg = 1'b1;
            // Key colour lets the background show through
            MODE_CHROMA_KEY: mode_fg = (fg_pixel != ctrl.key_color);
            default:         mode_fg = 1'b0;
        endcase
    end

    assign use_fg = fg_valid && mode_fg;

    assign mix_r = R_WIDTH'(blend_channel(G_WIDTH'(fg_r), G_WIDTH'(bg_r), ctrl.transparency));
    assign mix_g = blend_channel(fg_g, bg_g, ctrl.transparency);
    assign mix_b = B_WIDTH'(blend_channel(G_WIDTH'(fg_b), G_WIDTH'(bg_b), ctrl.transparency));

    assign result = use_fg ? {mix_r, mix_g, mix_b} : held.pixel;

    // --------------------
    // Output register
    // --------------------

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            pix_out_valid <= 1'b0;
        else
            pix_out_valid <= held_valid;
    end

    always_ff @(posedge clk)
    begin
        if (held_valid)
        begin
            pix_out.pixel <= result;
            pix_out.x     <= held.x;
            pix_out.y     <= held.y;
        end
    end

endmodule

`default_nettype wire

// ==== hw/bg_delay_line.sv ====
`timescale 1ns/1ps
`default_nettype none

module bg_delay_line (
    input  logic                       clk,
    input  logic                       rst_n,
    input  overlay_pkg::screen_pixel_t bg,
    input  logic                       bg_valid,
    output overlay_pkg::screen_pixel_t held,
    output logic                       held_valid
);

    import video_pkg::*;
    import overlay_pkg::*;

    // Last entry lines up with fg_valid from the memory
    screen_pixel_t             stage_data [FG_FETCH_DELAY];
    logic [FG_FETCH_DELAY-1:0] stage_valid;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            stage_valid <= '0;
        else
            stage_valid <= {stage_valid[FG_FETCH_DELAY-2:0], bg_valid};
    end

    // --------------------
    // Data chain
    // --------------------

    // An entry loads only when the one before it holds a live pixel
    always_ff @(posedge clk)
    begin
        if (bg_valid)
            stage_data[0] <= bg;
        for (int i = 1; i < FG_FETCH_DELAY; i++)
        begin
            if (stage_valid[i-1])
                stage_data[i] <= stage_data[i-1];
        end
    end

    assign held       = stage_data[FG_FETCH_DELAY-1];
    assign held_valid = stage_valid[FG_FETCH_DELAY-1];

endmodule

`default_nettype wire

// ==== hw/fg_clip.sv ====
`timescale 1ns/1ps
`default_nettype none

module fg_clip (
    input  overlay_pkg::fg_request_t request,
    input  logic                     raw_active,
    input  video_pkg::coord_t        clip_left,
    input  video_pkg::coord_t        clip_right,
    input  video_pkg::coord_t        clip_top,
    input  video_pkg::coord_t        clip_bottom,
    output logic                     active
);

    import video_pkg::*;

    // Clip bounds widened to signed so they compare against the request directly
    fg_coord_t clip_l;
    fg_coord_t clip_r;
    fg_coord_t clip_t;
    fg_coord_t clip_b;
    logic      inside_x;
    logic      inside_y;

    assign clip_l = {1'b0, clip_left};
    assign clip_r = {1'b0, clip_right};
    assign clip_t = {1'b0, clip_top};
    assign clip_b = {1'b0, clip_bottom};

    // An inverted window fails one of these for every coordinate
    assign inside_x = (request.x >= clip_l) && (request.x <= clip_r);
    assign inside_y = (request.y >= clip_t) && (request.y <= clip_b);

    // Image bounds were already checked upstream
    assign active = raw_active && inside_x && inside_y;

endmodule

`default_nettype wire

// ==== hw/fg_request_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module fg_request_gen (
    input  logic                     clk,
    input  logic                     rst_n,
    input  video_pkg::coord_t        x,
    input  video_pkg::coord_t        y,
    input  logic                     bg_valid,
    input  overlay_pkg::fg_scale_t   scale,
    input  video_pkg::fg_coord_t     offset_x,
    input  video_pkg::fg_coord_t     offset_y,
    output overlay_pkg::fg_request_t request,
    output logic                     raw_active
);

    import video_pkg::*;

    // One spare bit so position minus offset never wraps
    typedef logic signed [FG_COORD_WIDTH:0] wide_coord_t;

    wide_coord_t diff_x;
    wide_coord_t diff_y;
    wide_coord_t fg_x;
    wide_coord_t fg_y;
    logic        in_bounds;

    // --------------------
    // Coordinate mapping
    // --------------------

    always_comb
    begin
        diff_x = wide_coord_t'({2'b00, x}) - wide_coord_t'(offset_x);
        diff_y = wide_coord_t'({2'b00, y}) - wide_coord_t'(offset_y);

        // Arithmetic shift keeps negative positions negative
        fg_x = diff_x >>> scale;
        fg_y = diff_y >>> scale;

        in_bounds = (fg_x >= 0) && (fg_x < FG_WIDTH) &&
                    (fg_y >= 0) && (fg_y < FG_HEIGHT);
    end

    // --------------------
    // Request register
    // --------------------

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            raw_active <= 1'b0;
        else
            raw_active <= bg_valid && in_bounds;
    end

    // Address only moves on a strobe
    always_ff @(posedge clk)
    begin
        if (bg_valid)
        begin
            request.x <= fg_x[FG_COORD_WIDTH-1:0];
            request.y <= fg_y[FG_COORD_WIDTH-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== hw/overlay_pkg.sv ====
`default_nettype none

package overlay_pkg;

    // --------------------
    // Control
    // --------------------

    // Reserved code acts as off
    typedef enum logic [1:0] {
        MODE_OFF        = 2'd0,
        MODE_OVERLAY    = 2'd1,
        MODE_CHROMA_KEY = 2'd2,
        MODE_RESERVED   = 2'd3
    } overlay_mode_e;

    // Right shift of the screen offset, magnifying the foreground 1x to 8x
    typedef logic [1:0] fg_scale_t;

    typedef struct packed {
        overlay_mode_e       mode;
        fg_scale_t           scale;
        video_pkg::fg_coord_t offset_x;
        video_pkg::fg_coord_t offset_y;
        video_pkg::alpha_t   transparency;
        // Clip bounds in foreground coordinates, inclusive
        video_pkg::coord_t   clip_left;
        video_pkg::coord_t   clip_right;
        video_pkg::coord_t   clip_top;
        video_pkg::coord_t   clip_bottom;
        video_pkg::pixel_t   key_color;
    } overlay_ctrl_t;

    // --------------------
    // Pixel streams
    // --------------------

    // Pixel plus its screen position, 38 bits
    typedef struct packed {
        video_pkg::pixel_t pixel;
        video_pkg::coord_t x;
        video_pkg::coord_t y;
    } screen_pixel_t;

    // Read address towards the foreground memory
    typedef struct packed {
        video_pkg::fg_coord_t x;
        video_pkg::fg_coord_t y;
    } fg_request_t;

endpackage

`default_nettype wire

// ==== hw/video_pkg.sv ====
`default_nettype none

package video_pkg;

    // --------------------
    // Pixel format
    // --------------------

    // RGB565, red in the top bits
    localparam int R_WIDTH     = 5;
    localparam int G_WIDTH     = 6;
    localparam int B_WIDTH     = 5;
    localparam int PIXEL_WIDTH = R_WIDTH + G_WIDTH + B_WIDTH;

    typedef logic [R_WIDTH-1:0]     red_t;
    typedef logic [G_WIDTH-1:0]     green_t;
    typedef logic [B_WIDTH-1:0]     blue_t;
    typedef logic [PIXEL_WIDTH-1:0] pixel_t;

    // --------------------
    // Geometry and timing
    // --------------------

    localparam int COORD_WIDTH    = 11;
    // Foreground coordinates carry a sign bit on top of the screen width
    localparam int FG_COORD_WIDTH = COORD_WIDTH + 1;

    localparam int RES_X     = 800;
    localparam int RES_Y     = 600;
    localparam int FG_WIDTH  = 256;
    localparam int FG_HEIGHT = 192;

    // Cycles from the background strobe edge to the returned foreground pixel
    localparam int FG_FETCH_DELAY = 6;

    localparam int ALPHA_WIDTH = 3;

    typedef logic [COORD_WIDTH-1:0]           coord_t;
    typedef logic signed [FG_COORD_WIDTH-1:0] fg_coord_t;
    // 0 is an opaque foreground
    typedef logic [ALPHA_WIDTH-1:0]           alpha_t;

endpackage

`default_nettype wire
